// File: Bender.yml
package:
  name: tft_subsystem

sources:
  - src/ahb_pkg.sv
  - src/tft_pkg.sv
  - src/pixel_fifo.sv
  - src/tft_timing.sv
  - src/tft_dma_reader.sv
  - src/pattern_slave.sv
  - src/tft_pixel_out.sv
  - src/tft_subsystem.sv
  - target: test
    files:
      - bench/tft_properties.sv
      - bench/tft_tb.sv

// File: bench/tft_properties.sv
module tft_properties import ahb_pkg::*; (
    input logic     clk_sys,
    input logic     rst_n,
    input ahb_req_t bus_req,
    input ahb_rsp_t bus_rsp,
    input logic     tft_hsync,
    input logic     tft_vsync,
    input logic     tft_de
);

    int unsigned fail_count = 0;  // Failed assertions so far

    // A stalled data phase must not disturb the pending address phase
    bus_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !bus_rsp.hready |=> $stable(bus_req))
    else begin
        $error("bus address or control changed while hready was low");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clk_sys)
        $rose(rst_n) |-> bus_req.htrans == TRANS_IDLE)
    else begin
        $error("htrans was not idle when reset was released");
        fail_count++;
    end

    de_outside_sync: assert property (@(posedge clk_sys) disable iff (!rst_n)
        tft_de |-> !tft_hsync && !tft_vsync)
    else begin
        $error("display enable was high during a sync pulse");
        fail_count++;
    end

endmodule

bind tft_subsystem tft_properties props (
    .clk_sys   (clk_sys),
    .rst_n     (rst_n),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .tft_hsync (tft_hsync),
    .tft_vsync (tft_vsync),
    .tft_de    (tft_de)
);

// File: bench/tft_stimulus.txt
# name  mode(0 solid, 1 gradient, 2 checker)  colour(hex rgb)  wait_states  frames
# last column is the expected underflow flag
solid_red      0  ff0000  0  2  0
solid_teal     0  2a9d8f  1  2  0
gradient_w0    1  000000  0  2  0
gradient_w2    1  000000  2  1  0
checker_w3     2  000000  3  2  0
checker_w0     2  000000  0  1  0
gradient_w3    1  000000  3  1  0
solid_w3       0  5aa53c  3  1  0

// File: bench/tft_tb.sv
module tft_tb import tft_pkg::*; ();

    localparam int    HALF_PERIOD  = 10;
    localparam int    DRIVE_DELAY  = 2;
    localparam int    RESET_CYCLES = 3;
    localparam int    FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam string STIM_FILE    = "bench/tft_stimulus.txt";

    logic          clk_sys;
    logic          rst_n;
    pattern_mode_t mode;
    pixel_t        solid_color;
    logic [1:0]    wait_states;
    pixel_t        tft_rgb;
    logic          tft_hsync;
    logic          tft_vsync;
    logic          tft_de;
    logic          underflow;

    // One entry per stimulus line
    string         test_name[$];
    pattern_mode_t test_mode[$];
    pixel_t        test_color[$];
    logic [1:0]    test_wait[$];
    int            test_frames[$];
    logic          test_uflow[$];

    int     errors;
    int     test_errors;
    int     checks;
    int     failed_tests;
    int     cycle_count;
    int     cycle_limit;
    integer seed;

    tft_subsystem dut0 (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .mode        (mode),
        .solid_color (solid_color),
        .wait_states (wait_states),
        .tft_rgb     (tft_rgb),
        .tft_hsync   (tft_hsync),
        .tft_vsync   (tft_vsync),
        .tft_de      (tft_de),
        .underflow   (underflow)
    );

    always #HALF_PERIOD clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles with tests still running", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_scan(input logic got_hs, got_vs, got_de,
                              input logic exp_hs, exp_vs, exp_de);
        checks++;
        if (got_hs !== exp_hs) begin
            $display("ERROR t=%0t tft_hsync got %b expected %b", $time, got_hs, exp_hs);
            test_errors++;
        end
        if (got_vs !== exp_vs) begin
            $display("ERROR t=%0t tft_vsync got %b expected %b", $time, got_vs, exp_vs);
            test_errors++;
        end
        if (got_de !== exp_de) begin
            $display("ERROR t=%0t tft_de got %b expected %b", $time, got_de, exp_de);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // Image pixel at active column x and active line y
    function automatic pixel_t pattern_pixel(input pattern_mode_t m, input pixel_t solid,
                                             input int x, input int y);
        pixel_t p;
        p = '0;
        case (m)
            MODE_SOLID: p = solid;
            MODE_GRADIENT: begin
                p.r = 8'(x * 32);
                p.g = 8'(y * 64);
                p.b = 8'(x + y);
            end
            MODE_CHECKER: begin
                if ((x + y) % 2 == 1) begin
                    p = 24'hff_ffff;  // White where the squares alternate
                end
            end
            default: p = '0;
        endcase
        return p;
    endfunction

    task automatic load_tests();
        int          fd;
        int          fields;
        int          m;
        int          w;
        int          fr;
        int          uf;
        logic [23:0] c;
        string       line;
        string       name;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;  // Comment or blank line
                end
                fields = $sscanf(line, "%s %d %h %d %d %d", name, m, c, w, fr, uf);
                if (fields != 6) begin
                    $display("Stimulus line not understood: %s", line);
                    errors++;
                end else begin
                    test_name.push_back(name);
                    test_mode.push_back(pattern_mode_t'(m[1:0]));
                    test_color.push_back(pixel_t'(c));
                    test_wait.push_back(w[1:0]);
                    test_frames.push_back(fr);
                    test_uflow.push_back(uf[0]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int n);
        int     total;
        int     k;
        int     h;
        int     v;
        logic   in_disp;
        pixel_t exp_px;
        test_errors = 0;
        total = (test_frames[n] + 1) * FRAME_CYCLES;
        @(posedge clk_sys);
        #DRIVE_DELAY;
        rst_n       = 1'b0;
        mode        = test_mode[n];
        solid_color = test_color[n];
        wait_states = test_wait[n];
        // Outputs stay quiet in reset and until the first clock after it
        for (k = 0; k <= RESET_CYCLES; k++) begin
            @(negedge clk_sys);
            check_scan(tft_hsync, tft_vsync, tft_de, 1'b0, 1'b0, 1'b0);
            check_flag("underflow", underflow, 1'b0);
            check_pixel("tft_rgb", tft_rgb, '0);
            if (k < RESET_CYCLES) begin
                @(posedge clk_sys);
                #DRIVE_DELAY;
            end
            if (k == RESET_CYCLES - 1) begin
                rst_n = 1'b1;
            end
        end
        for (k = 0; k < total; k++) begin
            @(negedge clk_sys);
            h = k % H_TOTAL;
            v = (k / H_TOTAL) % V_TOTAL;
            // The first frame after reset is blank while the FIFO fills
            in_disp = k >= FRAME_CYCLES && h >= H_ACT_START && h < H_ACT_END
                      && v >= V_ACT_START && v < V_ACT_END;
            exp_px = '0;
            if (in_disp) begin
                exp_px = pattern_pixel(test_mode[n], test_color[n],
                                       h - H_ACT_START, v - V_ACT_START);
            end
            check_scan(tft_hsync, tft_vsync, tft_de, h < H_SYNC, v < V_SYNC, in_disp);
            check_pixel("tft_rgb", tft_rgb, exp_px);
            check_flag("underflow", underflow, test_uflow[n]);
        end
        errors += test_errors;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %0d %s mode %0d wait %0d frames %0d: %0d errors", n, test_name[n],
                 test_mode[n], test_wait[n], test_frames[n], test_errors);
    endtask

    initial begin
        int gap;
        clk_sys      = 1'b0;
        rst_n        = 1'b0;
        mode         = MODE_SOLID;
        solid_color  = '0;
        wait_states  = '0;
        errors       = 0;
        test_errors  = 0;
        checks       = 0;
        failed_tests = 0;
        cycle_count  = 0;
        seed         = 10681;
        load_tests();
        cycle_limit = 100;
        foreach (test_frames[i]) begin
            cycle_limit += (test_frames[i] + 1) * FRAME_CYCLES + RESET_CYCLES + 8;
        end
        if (test_frames.size() == 0) begin
            $display("No tests were read from %s", STIM_FILE);
            errors++;
        end
        foreach (test_frames[i]) begin
            gap = $random(seed) & 3;  // A few idle clocks between tests
            repeat (gap) @(posedge clk_sys);
            run_test(i);
        end
        errors += dut0.props.fail_count;
        $display("tests %0d, failed %0d, checks %0d, assertion failures %0d, errors %0d",
                 test_frames.size(), failed_tests, checks, dut0.props.fail_count, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
src/ahb_pkg.sv
src/tft_pkg.sv
src/pixel_fifo.sv
src/tft_timing.sv
src/tft_dma_reader.sv
src/pattern_slave.sv
src/tft_pixel_out.sv
src/tft_subsystem.sv
bench/tft_properties.sv
bench/tft_tb.sv

// File: src/ahb_pkg.sv
package ahb_pkg;

    localparam int BURST_LEN = 8;  // Beats in an INCR8 burst

    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'b00,
        TRANS_BUSY   = 2'b01,
        TRANS_NONSEQ = 2'b10,
        TRANS_SEQ    = 2'b11
    } trans_t;

    // Full HBURST encoding, the DMA only issues SINGLE at reset and INCR8
    typedef enum logic [2:0] {
        BURST_SINGLE = 3'b000,
        BURST_INCR   = 3'b001,
        BURST_WRAP4  = 3'b010,
        BURST_INCR4  = 3'b011,
        BURST_WRAP8  = 3'b100,
        BURST_INCR8  = 3'b101,
        BURST_WRAP16 = 3'b110,
        BURST_INCR16 = 3'b111
    } burst_t;

    typedef struct packed {
        logic [31:0] haddr;
        trans_t      htrans;
        burst_t      hburst;
        logic        hwrite;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;  // Only OKAY is ever returned
    } ahb_rsp_t;

endpackage

// File: src/pattern_slave.sv
module pattern_slave import ahb_pkg::*, tft_pkg::*; (
    input  logic          clk_sys,
    input  logic          rst_n,
    input  ahb_req_t      bus_req,
    output ahb_rsp_t      bus_rsp,
    input  pattern_mode_t mode,
    input  pixel_t        solid_color,
    input  logic [1:0]    wait_states
);

    logic        dphase_q;
    logic [1:0]  wait_cnt;
    logic [31:0] addr_q;
    logic        ready;
    logic        accept;
    logic [31:0] index;
    logic [7:0]  px;
    logic [7:0]  py;
    pixel_t      pixel;

    assign ready  = !dphase_q || wait_cnt == '0;
    assign accept = ready && !bus_req.hwrite
                    && bus_req.htrans inside {TRANS_NONSEQ, TRANS_SEQ};

    // Wait states model the access latency at the head of a burst
    // Sequential beats then stream at one per clock
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            dphase_q <= 1'b0;
            wait_cnt <= '0;
        end else if (ready) begin
            dphase_q <= accept;
            wait_cnt <= (accept && bus_req.htrans == TRANS_NONSEQ) ? wait_states : 2'd0;
        end else begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            addr_q <= bus_req.haddr;
        end
    end

    assign index = (addr_q - FRAME_BASE) >> 2;
    assign px    = 8'(index % H_DISP);
    assign py    = 8'(index / H_DISP);

    always_comb begin
        pixel = '0;
        case (mode)
            MODE_SOLID: pixel = solid_color;
            MODE_GRADIENT: begin
                pixel.r = 8'(px * 32);
                pixel.g = 8'(py * 64);
                pixel.b = px + py;
            end
            MODE_CHECKER: begin
                if (px[0] ^ py[0]) begin
                    pixel = '1;
                end
            end
            default: pixel = '0;
        endcase
        bus_rsp.hrdata = {8'h00, pixel};
        bus_rsp.hready = ready;
        bus_rsp.hresp  = 1'b0;
    end

endmodule

// File: src/pixel_fifo.sv
module pixel_fifo import tft_pkg::*; #(
    parameter type entry_t = pixel_t
) (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic                  push,
    input  entry_t                wdata,
    input  logic                  pop,
    output entry_t                rdata,
    output logic [FIFO_CNT_W-1:0] count,
    output logic                  empty
);

    entry_t                mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign empty   = count == '0;
    assign do_push = push && count != FIFO_CNT_W'(FIFO_DEPTH);
    assign do_pop  = pop && !empty;
    assign rdata   = mem[rd_ptr];  // Head is visible before it is popped

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
            end
            count <= count + FIFO_CNT_W'(do_push) - FIFO_CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

// File: src/tft_dma_reader.sv
module tft_dma_reader import ahb_pkg::*, tft_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic                  frame_start,
    input  logic [FIFO_CNT_W-1:0] fifo_count,
    output ahb_req_t              bus_req,
    input  ahb_rsp_t              bus_rsp,
    output logic                  push,
    output pixel_t                push_data
);

    logic [31:0]           haddr_q;
    trans_t                htrans_q;
    burst_t                hburst_q;
    logic [2:0]            beats_left;  // Beats of this burst still to be addressed
    logic [5:0]            fetch_idx;   // Next frame word to address
    logic [FIFO_CNT_W-1:0] pending;     // Beats of started bursts not yet pushed
    logic                  dphase_q;
    logic                  frame_done;
    logic                  room;
    logic                  issue_seq;
    logic                  issue_new;
    logic [31:0]           next_addr;

    assign frame_done = fetch_idx == 6'(FRAME_WORDS);

    // A new burst must fit next to everything the FIFO is already owed
    assign room      = int'(fifo_count) + int'(pending) + BURST_LEN <= FIFO_DEPTH;
    assign issue_seq = bus_rsp.hready && beats_left != '0;
    assign issue_new = bus_rsp.hready && beats_left == '0 && !frame_done && room;
    assign next_addr = FRAME_BASE + 32'({fetch_idx, 2'b00});

    assign push      = dphase_q && bus_rsp.hready;
    assign push_data = pixel_t'(bus_rsp.hrdata[23:0]);

    always_comb begin
        bus_req.haddr  = haddr_q;
        bus_req.htrans = htrans_q;
        bus_req.hburst = hburst_q;
        bus_req.hwrite = 1'b0;
    end

    // Address phase only moves on when the slave is ready
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            haddr_q    <= FRAME_BASE;
            htrans_q   <= TRANS_IDLE;
            hburst_q   <= BURST_SINGLE;
            beats_left <= '0;
        end else if (bus_rsp.hready) begin
            if (issue_seq) begin
                htrans_q   <= TRANS_SEQ;
                haddr_q    <= next_addr;
                beats_left <= beats_left - 3'd1;
            end else if (issue_new) begin
                htrans_q   <= TRANS_NONSEQ;
                hburst_q   <= BURST_INCR8;
                haddr_q    <= next_addr;
                beats_left <= 3'(BURST_LEN - 1);
            end else begin
                htrans_q <= TRANS_IDLE;
            end
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            fetch_idx <= 6'(FRAME_WORDS);  // Parked until the first frame start
            pending   <= '0;
            dphase_q  <= 1'b0;
        end else begin
            // A frame start mid-fetch is ignored, the reader runs a frame ahead
            if (frame_start && frame_done) begin
                fetch_idx <= '0;
            end else if (issue_seq || issue_new) begin
                fetch_idx <= fetch_idx + 6'd1;
            end
            pending <= pending + (issue_new ? FIFO_CNT_W'(BURST_LEN) : '0)
                       - FIFO_CNT_W'(push);
            if (bus_rsp.hready) begin
                dphase_q <= htrans_q inside {TRANS_NONSEQ, TRANS_SEQ};
            end
        end
    end

endmodule

// File: src/tft_pixel_out.sv
module tft_pixel_out import tft_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_n,
    input  scan_t  scan,
    input  pixel_t fifo_rdata,
    input  logic   fifo_empty,
    output logic   pop,
    output pixel_t rgb,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output logic   underflow
);

    assign pop = scan.de && !fifo_empty;

    // Everything lands on the pins one clock after the scan state
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rgb       <= '0;
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            de        <= 1'b0;
            underflow <= 1'b0;
        end else begin
            hsync <= scan.hsync;
            vsync <= scan.vsync;
            de    <= scan.de;
            rgb   <= pop ? fifo_rdata : '0;  // Black in blanking and on a starved pixel
            if (scan.de && fifo_empty) begin
                underflow <= 1'b1;  // Sticky until reset
            end
        end
    end

endmodule

// File: src/tft_pkg.sv
package tft_pkg;

    // Horizontal timing in clocks
    localparam int H_SYNC  = 1;
    localparam int H_BACK  = 2;
    localparam int H_DISP  = 8;
    localparam int H_FRONT = 3;

    // Vertical timing in lines
    localparam int V_SYNC  = 1;
    localparam int V_BACK  = 1;
    localparam int V_DISP  = 4;
    localparam int V_FRONT = 1;

    localparam int H_TOTAL = H_SYNC + H_BACK + H_DISP + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_DISP + V_FRONT;

    // First active counter value and one past the last
    localparam int H_ACT_START = H_SYNC + H_BACK;
    localparam int H_ACT_END   = H_ACT_START + H_DISP;
    localparam int V_ACT_START = V_SYNC + V_BACK;
    localparam int V_ACT_END   = V_ACT_START + V_DISP;

    localparam logic [31:0] FRAME_BASE  = 32'h0f00_0000;
    localparam int          FRAME_WORDS = H_DISP * V_DISP;  // One 32-bit word per pixel

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic       frame_start;
        logic [3:0] x;  // Raw horizontal counter, syncs and porches included
        logic [2:0] y;
    } scan_t;

    typedef enum logic [1:0] {
        MODE_SOLID    = 2'd0,
        MODE_GRADIENT = 2'd1,
        MODE_CHECKER  = 2'd2
    } pattern_mode_t;

endpackage

// File: src/tft_subsystem.sv
module tft_subsystem import ahb_pkg::*, tft_pkg::*; (
    input  logic          clk_sys,
    input  logic          rst_n,
    input  pattern_mode_t mode,
    input  pixel_t        solid_color,
    input  logic [1:0]    wait_states,
    output pixel_t        tft_rgb,
    output logic          tft_hsync,
    output logic          tft_vsync,
    output logic          tft_de,
    output logic          underflow
);

    scan_t                 scan;
    ahb_req_t              bus_req;
    ahb_rsp_t              bus_rsp;
    logic                  push;
    pixel_t                push_data;
    logic                  pop;
    pixel_t                fifo_rdata;
    logic [FIFO_CNT_W-1:0] fifo_count;
    logic                  fifo_empty;

    tft_timing timing (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .scan    (scan)
    );

    // DMA master on the frame bus
    tft_dma_reader dma (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .frame_start (scan.frame_start),
        .fifo_count  (fifo_count),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .push        (push),
        .push_data   (push_data)
    );

    pattern_slave ptn (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .mode        (mode),
        .solid_color (solid_color),
        .wait_states (wait_states)
    );

    pixel_fifo #(
        .entry_t (pixel_t)
    ) fifo (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .push    (push),
        .wdata   (push_data),
        .pop     (pop),
        .rdata   (fifo_rdata),
        .count   (fifo_count),
        .empty   (fifo_empty)
    );

    tft_pixel_out out (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .scan       (scan),
        .fifo_rdata (fifo_rdata),
        .fifo_empty (fifo_empty),
        .pop        (pop),
        .rgb        (tft_rgb),
        .hsync      (tft_hsync),
        .vsync      (tft_vsync),
        .de         (tft_de),
        .underflow  (underflow)
    );

endmodule

// File: src/tft_timing.sv
module tft_timing import tft_pkg::*; (
    input  logic  clk_sys,
    input  logic  rst_n,
    output scan_t scan
);

    logic [3:0] h_cnt;
    logic [2:0] v_cnt;
    logic       shown;  // Display is held off during the first frame
    logic       line_end;
    logic       frame_end;
    logic       h_act;
    logic       v_act;

    assign line_end  = h_cnt == 4'(H_TOTAL - 1);
    assign frame_end = line_end && v_cnt == 3'(V_TOTAL - 1);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
            shown <= 1'b0;
        end else begin
            if (line_end) begin
                h_cnt <= '0;
                if (frame_end) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 3'd1;
                end
            end else begin
                h_cnt <= h_cnt + 4'd1;
            end
            if (frame_end) begin
                shown <= 1'b1;
            end
        end
    end

    // Sync comes first in each line and frame, then back porch, display, front porch
    assign h_act = h_cnt >= 4'(H_ACT_START) && h_cnt < 4'(H_ACT_END);
    assign v_act = v_cnt >= 3'(V_ACT_START) && v_cnt < 3'(V_ACT_END);

    always_comb begin
        scan.hsync       = h_cnt < 4'(H_SYNC);
        scan.vsync       = v_cnt < 3'(V_SYNC);
        scan.de          = h_act && v_act && shown;
        scan.frame_start = h_cnt == '0 && v_cnt == '0;
        scan.x           = h_cnt;
        scan.y           = v_cnt;
    end

endmodule
